/* cfi_guard.f */
+incdir+logic
+incdir+sim
logic/cfi_pkg.sv
logic/return_stack.sv
logic/shadow_stack_check.sv
logic/landing_pad_check.sv
logic/exec_region_check.sv
logic/fault_arbiter.sv
logic/cfi_guard.sv
sim/cfi_guard_tb.sv

/* sim/cfi_model.svh */
/*
 * Reference model of the control-flow guard.
 * Follows the program's return addresses with an overflow count, the
 * two armed states and the region window, and predicts each report.
 */
`ifndef CFI_MODEL_SVH
`define CFI_MODEL_SVH

// copy of the return addresses and the number of calls still open
logic [`CFI_XLEN-1:0] m_stack [`CFI_STACK_DEPTH];
int                   m_depth;
logic                 m_wait_target;
logic                 m_wait_pad;
logic                 m_ret_known;
logic [`CFI_XLEN-1:0] m_ret_addr;
// a report sits one edge in m_pend before it reaches the outputs
logic [3:0]           m_pend_cause;
logic [`CFI_XLEN-1:0] m_pend_tval;
logic [3:0]           m_exp_cause;
logic [`CFI_XLEN-1:0] m_exp_tval;
logic                 m_exp_clear;

// an all-ones CSR accepts anything, a variadic callee needs at least the count
function automatic logic args_accepted(logic [`CFI_IMM_W-1:0] imm,
                                       logic [`CFI_ARGS_W-1:0] csr);
    logic [`CFI_ARGS_W-1:0] cnt;
    cnt = imm[`CFI_VARIADIC_BIT-1:2];
    return (csr == {`CFI_ARGS_W{1'b1}}) ||
           (imm[`CFI_VARIADIC_BIT] ? (cnt >= csr) : (cnt == csr));
endfunction

task automatic model_reset();
    m_depth       = 0;
    m_wait_target = 1'b0;
    m_wait_pad    = 1'b0;
    m_ret_known   = 1'b0;
    m_pend_cause  = 4'd0;
    m_pend_tval   = '0;
    m_exp_cause   = 4'd0;
    m_exp_tval    = '0;
    m_exp_clear   = 1'b0;
endtask

// one clock edge, reading the commit inputs that the DUT samples on it
task automatic model_step();
    logic call_r;
    logic ret_r;
    logic pad_r;
    logic ss_bad;
    logic lp_bad;
    logic nx_hit;
    m_exp_cause  = m_pend_cause;
    m_exp_tval   = m_pend_tval;
    m_pend_cause = 4'd0;
    m_pend_tval  = '0;
    m_exp_clear  = !csr_en_i;
    if (!csr_en_i) begin
        m_wait_target = 1'b0;
        m_wait_pad    = 1'b0;
    end else if (commit_valid_i && !commit_ex_i) begin
        // calls link into ra or t0, returns jump through them
        call_r = ((commit_op_i == cfi_pkg::OP_JAL) || (commit_op_i == cfi_pkg::OP_JALR)) &&
                 ((commit_rd_i == 5'd1) || (commit_rd_i == 5'd5));
        ret_r  = (commit_op_i == cfi_pkg::OP_JALR) && (commit_rd_i == 5'd0) &&
                 ((commit_rs1_i == 5'd1) || (commit_rs1_i == 5'd5));
        pad_r  = (commit_op_i == cfi_pkg::OP_ADD) && (commit_rd_i == 5'd0) &&
                 (commit_rs1_i == 5'd0) && (commit_imm_i[1:0] == 2'd2);
        ss_bad = m_wait_target && m_ret_known && (m_ret_addr != commit_pc_i);
        lp_bad = m_wait_pad && !(pad_r && args_accepted(commit_imm_i, csr_nb_args_i));
        nx_hit = (commit_pc_i >= region_start_i) && (commit_pc_i < region_end_i);
        m_exp_clear  = m_wait_pad;
        // stack beats landing pad beats region
        m_pend_cause = ss_bad ? 4'd1 : lp_bad ? 4'd5 : nx_hit ? 4'd7 : 4'd0;
        m_pend_tval  = (ss_bad || lp_bad || nx_hit) ? commit_pc_i : '0;
        if (ret_r) begin
            // entries pushed past the depth were never kept and cannot be checked
            m_ret_known = (m_depth > 0) && (m_depth <= `CFI_STACK_DEPTH);
            m_ret_addr  = m_ret_known ? m_stack[m_depth - 1] : '0;
            m_depth     = (m_depth > 0) ? m_depth - 1 : 0;
        end
        if (call_r) begin
            if (m_depth < `CFI_STACK_DEPTH) begin
                m_stack[m_depth] = commit_pc_i + 32'd4;
            end
            m_depth = m_depth + 1;
        end
        m_wait_target = ret_r;
        m_wait_pad    = call_r;
    end
endtask

`endif

/* sim/cfi_guard_tb.sv */
/*
 * Testbench for the control-flow guard.
 * Drives random and directed commit streams and compares the fault
 * report and the CSR clear pulse with a reference model every cycle.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module cfi_guard_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int NESTED_STEPS = 200;
    // every random step takes at most three cycles, the directed tests about 150
    localparam int RUN_CYCLES   = 4 + NESTED_STEPS * 3 + 12 * 2 + 150;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic                   csr_en_i;
    logic                   commit_valid_i;
    logic                   commit_ex_i;
    cfi_pkg::op_e           commit_op_i;
    logic [4:0]             commit_rd_i;
    logic [4:0]             commit_rs1_i;
    logic [`CFI_XLEN-1:0]   commit_pc_i;
    logic [`CFI_IMM_W-1:0]  commit_imm_i;
    logic [`CFI_ARGS_W-1:0] csr_nb_args_i;
    logic [`CFI_XLEN-1:0]   region_start_i;
    logic [`CFI_XLEN-1:0]   region_end_i;
    logic                   fault_valid_o;
    cfi_pkg::cause_e        fault_cause_o;
    logic [`CFI_XLEN-1:0]   fault_tval_o;
    logic                   csr_args_clear_o;

    logic [31:0] seed = 32'ha7be_0cef;
    logic        checking = 1'b0;
    int          errors = 0;
    int          test_errors = 0;
    int          checks_run = 0;
    int          tests_run = 0;
    int          clear_seen = 0;
    // reports seen in the current test, indexed by cause
    int          seen [16];

    `include "cfi_model.svh"

    cfi_guard UUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .csr_en_i         (csr_en_i),
        .commit_valid_i   (commit_valid_i),
        .commit_ex_i      (commit_ex_i),
        .commit_op_i      (commit_op_i),
        .commit_rd_i      (commit_rd_i),
        .commit_rs1_i     (commit_rs1_i),
        .commit_pc_i      (commit_pc_i),
        .commit_imm_i     (commit_imm_i),
        .csr_nb_args_i    (csr_nb_args_i),
        .region_start_i   (region_start_i),
        .region_end_i     (region_end_i),
        .fault_valid_o    (fault_valid_o),
        .fault_cause_o    (fault_cause_o),
        .fault_tval_o     (fault_tval_o),
        .csr_args_clear_o (csr_args_clear_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // model, checks and helpers
    ////////////////////////////////////////////////////////////////////////////

    // the model sees the same pre-edge inputs as the DUT
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk_i) begin
        if (checking) begin
            check_value("fault_valid_o", m_exp_cause != 4'd0, fault_valid_o);
            check_value("fault_cause_o", m_exp_cause, fault_cause_o);
            check_value("fault_tval_o", m_exp_tval, fault_tval_o);
            check_value("csr_args_clear_o", m_exp_clear, csr_args_clear_o);
            if (fault_valid_o) begin
                seen[fault_cause_o]++;
            end
            if (csr_args_clear_o) begin
                clear_seen++;
            end
        end
    end

    task automatic check_value(string name, logic [31:0] exp_v, logic [31:0] act_v);
        checks_run++;
        if (exp_v !== act_v) begin
            errors++;
            test_errors++;
            $display("Fail at %0t ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic drive_commit(logic valid, logic ex, cfi_pkg::op_e op, logic [4:0] rd,
                                logic [4:0] rs1, logic [31:0] pc, logic [11:0] imm);
        @(posedge clk_i);
        commit_valid_i <= valid;
        commit_ex_i    <= ex;
        commit_op_i    <= op;
        commit_rd_i    <= rd;
        commit_rs1_i   <= rs1;
        commit_pc_i    <= pc;
        commit_imm_i   <= imm;
    endtask

    task automatic call_at(logic [31:0] pc);
        drive_commit(1'b1, 1'b0, cfi_pkg::OP_JAL, 5'd1, 5'd0, pc, '0);
    endtask

    task automatic ret_at(logic [31:0] pc);
        drive_commit(1'b1, 1'b0, cfi_pkg::OP_JALR, 5'd0, 5'd1, pc, '0);
    endtask

    // marker immediate is variadic flag, argument count, then the tag
    task automatic pad_at(logic [31:0] pc, logic variadic, logic [8:0] cnt);
        drive_commit(1'b1, 1'b0, cfi_pkg::OP_ADD, 5'd0, 5'd0, pc, {variadic, cnt, 2'd2});
    endtask

    task automatic plain_at(logic [31:0] pc);
        drive_commit(1'b1, 1'b0, cfi_pkg::OP_OTHER, 5'd2, 5'd3, pc, '0);
    endtask

    // a bubble or an excepted call, neither of which retires
    task automatic skip_cycle(logic excepted);
        drive_commit(excepted, excepted, cfi_pkg::OP_JAL, 5'd1, 5'd0, 32'h0000_0040, '0);
    endtask

    task automatic drain();
        repeat (4) drive_commit(1'b0, 1'b0, cfi_pkg::OP_OTHER, 5'd0, 5'd0, '0, '0);
    endtask

    task automatic begin_test();
        foreach (seen[k]) seen[k] = 0;
        clear_seen  = 0;
        test_errors = 0;
    endtask

    task automatic end_test(string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_nested();
        logic [31:0] r;
        logic [8:0]  cnt;
        logic [31:0] ret_q [$];
        int          i;
        begin_test();
        for (i = 0; i < NESTED_STEPS; i++) begin
            r = lcg_next();
            if (r[31:29] < 3'd2) begin
                skip_cycle(r[20]);
            end else if ((r[31:29] < 3'd5) && (ret_q.size() < 12)) begin
                // nesting goes past the stack depth on purpose
                call_at(r & 32'h0fff_fffc);
                ret_q.push_back((r & 32'h0fff_fffc) + 32'd4);
                cnt = {1'b0, r[17:10]};
                csr_nb_args_i <= cnt;
                if (r[23]) begin
                    skip_cycle(r[24]);
                end
                pad_at(lcg_next() & 32'h0fff_fffc, r[21], cnt + {8'd0, r[21] & r[22]});
            end else if ((r[31:29] >= 3'd5) && (ret_q.size() > 0)) begin
                ret_at(r & 32'h0fff_fffc);
                plain_at(ret_q.pop_back());
            end else begin
                plain_at(r & 32'h0fff_fffc);
            end
        end
        while (ret_q.size() > 0) begin
            ret_at(32'h0000_0100);
            plain_at(ret_q.pop_back());
        end
        drain();
        check_value("fault count", 0, seen[1] + seen[5] + seen[7]);
        end_test("nested calls");
    endtask

    task automatic run_bad_return();
        int i;
        begin_test();
        csr_nb_args_i <= '1;
        call_at(32'h0000_1000);
        pad_at(32'h0000_2000, 1'b0, 9'd0);
        ret_at(32'h0000_2004);
        plain_at(32'h0000_1010);
        // ten calls deep, the two innermost return addresses are lost
        for (i = 0; i < 10; i++) begin
            call_at(32'h0000_3000 + i * 16);
            pad_at(32'h0000_5000 + i * 16, 1'b0, 9'd0);
        end
        for (i = 9; i >= 0; i--) begin
            ret_at(32'h0000_6000 + i * 16);
            plain_at((i >= 8) ? 32'h0000_7000 : 32'h0000_3004 + i * 16);
        end
        drain();
        check_value("stack fault count", 1, seen[1]);
        check_value("other fault count", 0, seen[5] + seen[7]);
        end_test("return target");
    endtask

    task automatic lp_case(logic [8:0] csr, logic has_pad, logic variadic, logic [8:0] cnt);
        call_at(32'h0000_8000);
        csr_nb_args_i <= csr;
        if (has_pad) begin
            pad_at(32'h0000_9000, variadic, cnt);
        end else begin
            plain_at(32'h0000_9000);
        end
    endtask

    task automatic run_landing_pad();
        begin_test();
        lp_case(9'd3, 1'b0, 1'b0, 9'd0);
        lp_case(9'd3, 1'b1, 1'b0, 9'd3);
        lp_case(9'd3, 1'b1, 1'b0, 9'd4);
        lp_case(9'd3, 1'b1, 1'b1, 9'd5);
        lp_case(9'd3, 1'b1, 1'b1, 9'd2);
        lp_case('1, 1'b1, 1'b0, 9'd7);
        drain();
        check_value("pad fault count", 3, seen[5]);
        check_value("other fault count", 0, seen[1] + seen[7]);
        check_value("clear pulse count", 6, clear_seen);
        end_test("landing pad");
    endtask

    task automatic run_region();
        begin_test();
        plain_at(32'h8000_0000);
        plain_at(32'h8000_0ffc);
        plain_at(32'h8000_1000);
        plain_at(32'h7fff_fffc);
        // a bad return target inside the window reports only the stack cause
        call_at(32'h0000_a000);
        csr_nb_args_i <= '1;
        pad_at(32'h0000_b000, 1'b0, 9'd0);
        ret_at(32'h0000_b004);
        plain_at(32'h8000_0100);
        drain();
        check_value("region fault count", 2, seen[7]);
        check_value("stack fault count", 1, seen[1]);
        check_value("pad fault count", 0, seen[5]);
        end_test("exec region");
    endtask

    task automatic run_disabled();
        begin_test();
        csr_en_i <= 1'b0;
        call_at(32'h0000_c000);
        plain_at(32'h0000_d000);
        ret_at(32'h0000_d004);
        plain_at(32'h8000_0000);
        drain();
        check_value("fault count", 0, seen[1] + seen[5] + seen[7]);
        end_test("guard disabled");
    endtask

    initial begin
        rst_ni         = 1'b0;
        csr_en_i       = 1'b1;
        commit_valid_i = 1'b0;
        commit_ex_i    = 1'b0;
        commit_op_i    = cfi_pkg::OP_OTHER;
        commit_rd_i    = 5'd0;
        commit_rs1_i   = 5'd0;
        commit_pc_i    = '0;
        commit_imm_i   = '0;
        csr_nb_args_i  = '1;
        region_start_i = 32'h8000_0000;
        region_end_i   = 32'h8000_1000;
        repeat (4) @(posedge clk_i);
        rst_ni   <= 1'b1;
        checking = 1'b1;
        run_nested();
        run_bad_return();
        run_landing_pad();
        run_region();
        run_disabled();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks_run, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // the run must end well within the cycles that the tests need
    initial begin
        #((RUN_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* logic/cfi_guard.sv */
/*
 * Commit-stage control-flow guard.
 * Watches one retired instruction per cycle and reports shadow stack,
 * landing-pad and non-executable region violations as access faults.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module cfi_guard (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   csr_en_i,
    input  logic                   commit_valid_i,
    input  logic                   commit_ex_i,
    input  cfi_pkg::op_e           commit_op_i,
    input  logic [4:0]             commit_rd_i,
    input  logic [4:0]             commit_rs1_i,
    input  logic [`CFI_XLEN-1:0]   commit_pc_i,
    input  logic [`CFI_IMM_W-1:0]  commit_imm_i,
    input  logic [`CFI_ARGS_W-1:0] csr_nb_args_i,
    input  logic [`CFI_XLEN-1:0]   region_start_i,
    input  logic [`CFI_XLEN-1:0]   region_end_i,
    output logic                   fault_valid_o,
    output cfi_pkg::cause_e        fault_cause_o,
    output logic [`CFI_XLEN-1:0]   fault_tval_o,
    output logic                   csr_args_clear_o
);

    logic                 retire;
    logic                 push, pop, top_valid;
    logic [`CFI_XLEN-1:0] push_addr, top_addr;
    logic                 ss_req, lp_req, nx_req;
    logic [`CFI_XLEN-1:0] ss_tval, lp_tval, nx_tval;

    // an instruction that raised an exception never really retired
    assign retire = commit_valid_i && !commit_ex_i;

    ////////////////////////////////////////////////////////////////////////////
    // checkers
    ////////////////////////////////////////////////////////////////////////////

    return_stack #(
        .DEPTH(`CFI_STACK_DEPTH)
    ) u_return_stack (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_addr_i (push_addr),
        .pop_i       (pop),
        .top_addr_o  (top_addr),
        .top_valid_o (top_valid)
    );

    shadow_stack_check u_shadow_stack_check (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .csr_en_i    (csr_en_i),
        .retire_i    (retire),
        .op_i        (commit_op_i),
        .rd_i        (commit_rd_i),
        .rs1_i       (commit_rs1_i),
        .pc_i        (commit_pc_i),
        .top_addr_i  (top_addr),
        .top_valid_i (top_valid),
        .push_o      (push),
        .push_addr_o (push_addr),
        .pop_o       (pop),
        .req_o       (ss_req),
        .req_tval_o  (ss_tval)
    );

    landing_pad_check u_landing_pad_check (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .csr_en_i     (csr_en_i),
        .retire_i     (retire),
        .op_i         (commit_op_i),
        .rd_i         (commit_rd_i),
        .rs1_i        (commit_rs1_i),
        .imm_i        (commit_imm_i),
        .pc_i         (commit_pc_i),
        .nb_args_i    (csr_nb_args_i),
        .req_o        (lp_req),
        .req_tval_o   (lp_tval),
        .args_clear_o (csr_args_clear_o)
    );

    exec_region_check u_exec_region_check (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .csr_en_i       (csr_en_i),
        .retire_i       (retire),
        .pc_i           (commit_pc_i),
        .region_start_i (region_start_i),
        .region_end_i   (region_end_i),
        .req_o          (nx_req),
        .req_tval_o     (nx_tval)
    );

    ////////////////////////////////////////////////////////////////////////////
    // fault report
    ////////////////////////////////////////////////////////////////////////////

    // requests arrive one cycle after retirement, the report one cycle later
    fault_arbiter u_fault_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ss_req_i      (ss_req),
        .ss_tval_i     (ss_tval),
        .lp_req_i      (lp_req),
        .lp_tval_i     (lp_tval),
        .nx_req_i      (nx_req),
        .nx_tval_i     (nx_tval),
        .fault_valid_o (fault_valid_o),
        .fault_cause_o (fault_cause_o),
        .fault_tval_o  (fault_tval_o)
    );

endmodule

/* logic/fault_arbiter.sv */
/*
 * Fault report arbiter.
 * Picks the highest-priority checker request each cycle (shadow stack,
 * landing pad, then region) and registers it as a one-cycle report.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module fault_arbiter (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 ss_req_i,
    input  logic [`CFI_XLEN-1:0] ss_tval_i,
    input  logic                 lp_req_i,
    input  logic [`CFI_XLEN-1:0] lp_tval_i,
    input  logic                 nx_req_i,
    input  logic [`CFI_XLEN-1:0] nx_tval_i,
    output logic                 fault_valid_o,
    output cfi_pkg::cause_e      fault_cause_o,
    output logic [`CFI_XLEN-1:0] fault_tval_o
);

    logic                 any_c;
    cfi_pkg::cause_e      cause_c;
    logic [`CFI_XLEN-1:0] tval_c;
    logic                 valid_q;
    cfi_pkg::cause_e      cause_q;
    logic [`CFI_XLEN-1:0] tval_q;

    assign any_c = ss_req_i || lp_req_i || nx_req_i;

    // losing requests are simply dropped, the trap only needs one cause
    always_comb begin
        cause_c = cfi_pkg::CAUSE_NONE;
        tval_c  = '0;
        if (ss_req_i) begin
            cause_c = cfi_pkg::CAUSE_INSTR_ACCESS;
            tval_c  = ss_tval_i;
        end else if (lp_req_i) begin
            cause_c = cfi_pkg::CAUSE_LOAD_ACCESS;
            tval_c  = lp_tval_i;
        end else if (nx_req_i) begin
            cause_c = cfi_pkg::CAUSE_STORE_ACCESS;
            tval_c  = nx_tval_i;
        end
    end

    // cause and tval read as zero whenever no report is out
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            cause_q <= cfi_pkg::CAUSE_NONE;
            tval_q  <= '0;
        end else begin
            valid_q <= any_c;
            cause_q <= cause_c;
            tval_q  <= tval_c;
        end
    end

    assign fault_valid_o = valid_q;
    assign fault_cause_o = cause_q;
    assign fault_tval_o  = tval_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fault_valid_o |-> (fault_cause_o != cfi_pkg::CAUSE_NONE))
        else $error("fault_arbiter report without a cause");

endmodule

/* logic/exec_region_check.sv */
/*
 * Non-executable region checker.
 * Flags any enabled retirement whose pc falls inside the half-open
 * window [region_start_i, region_end_i), one cycle later.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module exec_region_check (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 csr_en_i,
    input  logic                 retire_i,
    input  logic [`CFI_XLEN-1:0] pc_i,
    input  logic [`CFI_XLEN-1:0] region_start_i,
    input  logic [`CFI_XLEN-1:0] region_end_i,
    output logic                 req_o,
    output logic [`CFI_XLEN-1:0] req_tval_o
);

    logic                 hit_c;
    logic                 req_q;
    logic [`CFI_XLEN-1:0] tval_q;

    // an empty or inverted window never matches
    assign hit_c = csr_en_i && retire_i && (pc_i >= region_start_i) && (pc_i < region_end_i);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
        end else begin
            req_q <= hit_c;
        end
    end

    always_ff @(posedge clk_i) begin
        tval_q <= pc_i;
    end

    assign req_o      = req_q;
    assign req_tval_o = tval_q;

endmodule

/* logic/landing_pad_check.sv */
/*
 * Forward-edge checker.
 * The instruction retired after a call must be the landing-pad marker
 * and its argument count must agree with the indirect-call CSR. Each
 * test is followed by a pulse that clears the CSR.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module landing_pad_check (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  csr_en_i,
    input  logic                  retire_i,
    input  cfi_pkg::op_e          op_i,
    input  logic [4:0]            rd_i,
    input  logic [4:0]            rs1_i,
    input  logic [`CFI_IMM_W-1:0] imm_i,
    input  logic [`CFI_XLEN-1:0]  pc_i,
    input  logic [`CFI_ARGS_W-1:0] nb_args_i,
    output logic                  req_o,
    output logic [`CFI_XLEN-1:0]  req_tval_o,
    output logic                  args_clear_o
);

    typedef enum logic {
        IDLE,
        WAIT_PAD
    } state_e;

    state_e                 state_q, state_d;
    logic                   active;
    logic                   call_c;
    logic                   check_c;
    logic                   variadic_c;
    logic [`CFI_ARGS_W-1:0] pad_args_c;
    logic                   args_ok_c;
    logic                   pad_ok_c;
    logic                   req_q;
    logic                   clear_q;
    logic [`CFI_XLEN-1:0]   tval_q;

    assign active = retire_i && csr_en_i;
    assign call_c = active && cfi_pkg::is_call(op_i, rd_i);

    // the count sits just below the variadic flag in the marker immediate
    assign variadic_c = imm_i[`CFI_VARIADIC_BIT];
    assign pad_args_c = imm_i[`CFI_VARIADIC_BIT-1 -: `CFI_ARGS_W];

    // all ones in the CSR means no indirect call announced a count
    assign args_ok_c = (nb_args_i == '1) ||
                       (variadic_c && (pad_args_c >= nb_args_i)) ||
                       (!variadic_c && (pad_args_c == nb_args_i));
    assign pad_ok_c  = cfi_pkg::is_landing_pad(op_i, rd_i, rs1_i, imm_i) && args_ok_c;

    always_comb begin
        state_d = state_q;
        check_c = 1'b0;
        case (state_q)
            IDLE: begin
                if (call_c) begin
                    state_d = WAIT_PAD;
                end
            end
            WAIT_PAD: begin
                if (active) begin
                    check_c = 1'b1;
                    state_d = call_c ? WAIT_PAD : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
        if (!csr_en_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= check_c && !pad_ok_c;
            // the CSR is kept cleared while the guard is off
            clear_q <= check_c || !csr_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (check_c) begin
            tval_q <= pc_i;
        end
    end

    assign req_o        = req_q;
    assign req_tval_o   = tval_q;
    assign args_clear_o = clear_q;

    // every failed test is also a test, so the CSR clear goes out with it
    assert property (@(posedge clk_i) disable iff (!rst_ni) req_o |-> args_clear_o)
        else $error("landing_pad_check fault without CSR clear");

endmodule

/* logic/shadow_stack_check.sv */
/*
 * Backward-edge checker.
 * Pushes pc+4 for every retired call and pops on every retired return.
 * The popped address is compared with the pc of the next retired
 * instruction; a mismatch raises a one-cycle request.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module shadow_stack_check (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 csr_en_i,
    input  logic                 retire_i,
    input  cfi_pkg::op_e         op_i,
    input  logic [4:0]           rd_i,
    input  logic [4:0]           rs1_i,
    input  logic [`CFI_XLEN-1:0] pc_i,
    input  logic [`CFI_XLEN-1:0] top_addr_i,
    input  logic                 top_valid_i,
    output logic                 push_o,
    output logic [`CFI_XLEN-1:0] push_addr_o,
    output logic                 pop_o,
    output logic                 req_o,
    output logic [`CFI_XLEN-1:0] req_tval_o
);

    typedef enum logic {
        IDLE,
        WAIT_TARGET
    } state_e;

    state_e               state_q, state_d;
    logic                 active;
    logic                 call_c;
    logic                 ret_c;
    logic                 check_c;
    logic                 bad_c;
    logic [`CFI_XLEN-1:0] exp_addr_q;
    logic                 exp_valid_q;
    logic                 req_q;
    logic [`CFI_XLEN-1:0] tval_q;

    // with the guard disabled nothing retires as far as this checker knows
    assign active = retire_i && csr_en_i;
    assign call_c = active && cfi_pkg::is_call(op_i, rd_i);
    assign ret_c  = active && cfi_pkg::is_ret(op_i, rd_i, rs1_i);

    // the stack is written at the end of the call's own cycle
    assign push_o      = call_c;
    assign push_addr_o = pc_i + `CFI_XLEN'(4);
    assign pop_o       = ret_c;

    always_comb begin
        state_d = state_q;
        check_c = 1'b0;
        case (state_q)
            IDLE: begin
                if (ret_c) begin
                    state_d = WAIT_TARGET;
                end
            end
            WAIT_TARGET: begin
                if (active) begin
                    check_c = 1'b1;
                    // a return landing on another return waits again
                    state_d = ret_c ? WAIT_TARGET : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
        if (!csr_en_i) begin
            state_d = IDLE;
        end
    end

    // a lost entry cannot be checked, so only a valid mismatch is a fault
    assign bad_c = check_c && exp_valid_q && (exp_addr_q != pc_i);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= bad_c;
        end
    end

    // latch what the pop returned and the pc of a bad target
    always_ff @(posedge clk_i) begin
        if (ret_c) begin
            exp_addr_q  <= top_addr_i;
            exp_valid_q <= top_valid_i;
        end
        if (bad_c) begin
            tval_q <= pc_i;
        end
    end

    assign req_o      = req_q;
    assign req_tval_o = tval_q;

endmodule

/* logic/return_stack.sv */
/*
 * Return address stack.
 * Holds DEPTH addresses. The pointer keeps counting past the depth so
 * that deep call chains stay balanced; entries beyond the array are lost
 * and their pops report an invalid top.
 */
`timescale 1ns/1ns
`include "cfi_macros.svh"

module return_stack #(
    parameter int DEPTH = `CFI_STACK_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  logic [`CFI_XLEN-1:0] push_addr_i,
    input  logic                 pop_i,
    output logic [`CFI_XLEN-1:0] top_addr_o,
    output logic                 top_valid_o
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // eight spare bits let the pointer run far past the array before saturating
    localparam int PTR_W = IDX_W + 8;

    logic [`CFI_XLEN-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]     ptr_q;
    logic [IDX_W-1:0]     top_idx;
    logic                 in_array;

    // ptr_q counts stored entries, so the top lives one slot below it
    assign top_idx     = IDX_W'(ptr_q - PTR_W'(1));
    assign top_valid_o = (ptr_q != '0) && (ptr_q <= PTR_W'(DEPTH));
    assign top_addr_o  = top_valid_o ? mem_q[top_idx] : '0;

    // a push only lands in the array while there is room left
    assign in_array = (ptr_q < PTR_W'(DEPTH));

    always_ff @(posedge clk_i) begin
        if (push_i && in_array) begin
            mem_q[ptr_q[IDX_W-1:0]] <= push_addr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (push_i && (ptr_q != '1)) begin
            ptr_q <= ptr_q + PTR_W'(1);
        end else if (pop_i && (ptr_q != '0)) begin
            // popping an empty stack leaves the pointer at zero
            ptr_q <= ptr_q - PTR_W'(1);
        end
    end

    // the checker never pushes and pops on the same retirement
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && pop_i))
        else $error("return_stack push and pop in the same cycle");

endmodule

/* logic/cfi_pkg.sv */
/*
 * Control-flow guard types.
 * Retired-operation and fault-cause encodings plus the helpers that
 * classify a retired instruction as a call, a return or a landing pad.
 */
`include "cfi_macros.svh"

package cfi_pkg;

    // operation class of the retired instruction, as reported by commit
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_JAL   = 3'd1,
        OP_JALR  = 3'd2,
        OP_OTHER = 3'd3
    } op_e;

    // causes follow the RISC-V mcause access-fault codes
    typedef enum logic [3:0] {
        CAUSE_NONE         = 4'd0,
        CAUSE_INSTR_ACCESS = 4'd1,
        CAUSE_LOAD_ACCESS  = 4'd5,
        CAUSE_STORE_ACCESS = 4'd7
    } cause_e;

    // a jump that links into ra or t0 is a call
    function automatic logic is_call(op_e op, logic [4:0] rd);
        return ((op == OP_JAL) || (op == OP_JALR)) && ((rd == 5'd1) || (rd == 5'd5));
    endfunction

    // a jalr that discards the link and jumps through ra or t0 is a return
    function automatic logic is_ret(op_e op, logic [4:0] rd, logic [4:0] rs1);
        return (op == OP_JALR) && (rd == 5'd0) && ((rs1 == 5'd1) || (rs1 == 5'd5));
    endfunction

    // the marker is an add to x0 from x0 whose immediate carries the tag
    function automatic logic is_landing_pad(op_e op, logic [4:0] rd, logic [4:0] rs1,
                                            logic [`CFI_IMM_W-1:0] imm);
        return (op == OP_ADD) && (rd == 5'd0) && (rs1 == 5'd0) &&
               (imm[1:0] == `CFI_NOP_IMM_TAG);
    endfunction

endpackage

/* logic/cfi_macros.svh */
/*
 * Control-flow guard widths and encodings.
 * Address and argument widths, the shadow stack depth and the fields
 * of the landing-pad marker instruction (addi x0, x0, imm).
 */
`ifndef CFI_MACROS_SVH
`define CFI_MACROS_SVH

// width of a program counter and of a stored return address
`define CFI_XLEN 32

// return addresses held before the stack starts dropping pushes
`define CFI_STACK_DEPTH 8

// argument count carried by the marker and by the CSR
`define CFI_ARGS_W 9

// immediate field of the marker no-op
`define CFI_IMM_W 12
// the low two immediate bits tag an add as a landing pad
`define CFI_NOP_IMM_TAG 2'd2
// set in the immediate when the callee takes a variable argument list
`define CFI_VARIADIC_BIT 11

`endif
